// File: Makefile
# Verilator build for the out-of-order core testbench
# Any variable can be overridden, e.g. make run BUILD_DIR=build

VERILATOR ?= verilator
TOP       ?= ooo_core_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing --timescale $(TIMESCALE) -Wno-fatal
PASS_TEXT ?= ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Output is shown and searched for the pass line; no match fails the target
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// File: source/alu_unit.sv
`default_nettype none

module alu_unit (
	input  wire                   clock,
	input  wire                   reset,
	input  wire core_pkg::issue_t issue,
	input  wire                   issue_valid,
	input  wire                   grant,
	output logic                  busy,
	output core_pkg::cdb_t        request
);
	import isa_pkg::*;

	logic [XLEN-1:0] result;

	always_comb begin
		case (issue.op)
			OP_ADD:  result = issue.a + issue.b;
			OP_SUB:  result = issue.a - issue.b;
			OP_AND:  result = issue.a & issue.b;
			OP_OR:   result = issue.a | issue.b;
			OP_XOR:  result = issue.a ^ issue.b;
			OP_SLT:  result = XLEN'($signed(issue.a) < $signed(issue.b));
			default: result = '0;  // MUL goes to the multiplier
		endcase
	end

	// Free again in the cycle the bus takes the held result
	assign busy = request.valid && !grant;

	always_ff @(posedge clock) begin
		if (reset) begin
			request <= '0;
		end else if (issue_valid) begin
			request <= '{valid: 1'b1, tag: issue.tag, value: result};
		end else if (grant) begin
			request.valid <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: source/cdb_arbiter.sv
`default_nettype none

module cdb_arbiter (
	input  wire                 clock,
	input  wire                 reset,
	input  wire core_pkg::cdb_t alu_request,
	input  wire core_pkg::cdb_t mul_request,
	output logic                alu_grant,
	output logic                mul_grant,
	output core_pkg::cdb_t      cdb
);

	logic mul_first;  // Round-robin pointer

	assign alu_grant = alu_request.valid && (!mul_request.valid || !mul_first);
	assign mul_grant = mul_request.valid && (!alu_request.valid || mul_first);

	always_comb begin
		if (alu_grant)
			cdb = alu_request;
		else if (mul_grant)
			cdb = mul_request;
		else
			cdb = '0;  // Idle bus
	end

	// Flip only on a real conflict so the loser wins next time
	always_ff @(posedge clock) begin
		if (reset)
			mul_first <= 1'b0;
		else if (alu_request.valid && mul_request.valid)
			mul_first <= !mul_first;
	end

endmodule

`default_nettype wire

// File: source/core_pkg.sv
`default_nettype none

package core_pkg;

	localparam int ROB_SIZE = 8;  // Power of two so pointers wrap freely

	typedef logic [$clog2(ROB_SIZE)-1:0] rob_tag_t;

	// Source operand as seen by the station
	typedef struct packed {
		logic                     ready;
		rob_tag_t                 tag;    // Producer while not ready
		logic [isa_pkg::XLEN-1:0] value;
	} operand_t;

	// Station to functional unit
	typedef struct packed {
		isa_pkg::opcode_t         op;
		rob_tag_t                 tag;
		logic [isa_pkg::XLEN-1:0] a;
		logic [isa_pkg::XLEN-1:0] b;
	} issue_t;

	// Common data bus beat, also used for unit requests
	typedef struct packed {
		logic                     valid;
		rob_tag_t                 tag;
		logic [isa_pkg::XLEN-1:0] value;
	} cdb_t;

	// ROB answer to an operand query
	typedef struct packed {
		logic                     hit;    // Entry already done
		logic [isa_pkg::XLEN-1:0] value;
	} rob_lookup_t;

endpackage

`default_nettype wire

// File: source/isa_pkg.sv
`default_nettype none

package isa_pkg;

	localparam int XLEN     = 32;  // Data path width
	localparam int NUM_REGS = 16;  // Architectural registers

	typedef logic [$clog2(NUM_REGS)-1:0] reg_idx_t;

	// MUL keeps only the low word of the product
	// SLT yields 1 or 0 from a signed compare
	typedef enum logic [2:0] {
		OP_ADD = 3'd0,
		OP_SUB = 3'd1,
		OP_AND = 3'd2,
		OP_OR  = 3'd3,
		OP_XOR = 3'd4,
		OP_SLT = 3'd5,
		OP_MUL = 3'd6
	} opcode_t;

	// Decoded instruction at the dispatch port
	typedef struct packed {
		opcode_t         op;
		reg_idx_t        rd;       // Destination
		reg_idx_t        rs1;
		reg_idx_t        rs2;
		logic            use_imm;  // Imm stands in for rs2
		logic [XLEN-1:0] imm;
	} instr_t;

endpackage

`default_nettype wire

// File: source/multiplier_unit.sv
`default_nettype none

module multiplier_unit #(
	parameter int MUL_STAGES = 3
) (
	input  wire                   clock,
	input  wire                   reset,
	input  wire core_pkg::issue_t issue,
	input  wire                   issue_valid,
	input  wire                   grant,
	output logic                  busy,
	output core_pkg::cdb_t        request
);
	import isa_pkg::*;
	import core_pkg::*;

	localparam int CHUNK = (XLEN + MUL_STAGES - 1) / MUL_STAGES;  // Multiplier bits per stage

	typedef struct packed {
		logic            valid;
		rob_tag_t        tag;
		logic [XLEN-1:0] a;    // Multiplicand lined up with the next chunk
		logic [XLEN-1:0] b;    // Multiplier bits not yet consumed
		logic [XLEN-1:0] acc;  // Partial product so far
	} stage_t;

	stage_t pipe [MUL_STAGES];

	// Fold one chunk of b into the product
	function automatic stage_t step(stage_t s);
		stage_t n;
		n     = s;
		n.acc = s.acc + s.a * XLEN'(s.b[CHUNK-1:0]);
		n.a   = s.a << CHUNK;
		n.b   = s.b >> CHUNK;
		return n;
	endfunction

	// Whole pipe freezes behind an ungranted result
	assign busy = pipe[MUL_STAGES-1].valid && !grant;

	assign request = '{
		valid: pipe[MUL_STAGES-1].valid,
		tag:   pipe[MUL_STAGES-1].tag,
		value: pipe[MUL_STAGES-1].acc
	};

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < MUL_STAGES; i++)
				pipe[i] <= '0;
		end else if (!busy) begin
			pipe[0] <= step('{valid: issue_valid, tag: issue.tag, a: issue.a, b: issue.b,
				acc: '0});
			for (int i = 1; i < MUL_STAGES; i++)
				pipe[i] <= step(pipe[i-1]);
		end
	end

endmodule

`default_nettype wire

// File: source/ooo_core.sv
`default_nettype none

module ooo_core #(
	parameter int RS_DEPTH   = 4,
	parameter int MUL_STAGES = 3
) (
	input  wire                       clock,
	input  wire                       reset,
	input  wire                       in_valid,
	input  wire isa_pkg::instr_t      in_instr,
	output logic                      dispatch_ready,
	output logic                      commit_valid,
	output isa_pkg::reg_idx_t         commit_reg,
	output logic [isa_pkg::XLEN-1:0]  commit_value
);
	import isa_pkg::*;
	import core_pkg::*;

	logic            dispatch_en;
	logic            rob_full;
	logic            rs_full;
	rob_tag_t        tail_tag;
	operand_t        op1;
	operand_t        op2;
	operand_t        op_b;          // rs2 or immediate
	rob_lookup_t     look_a;
	rob_lookup_t     look_b;
	cdb_t            cdb;
	issue_t          alu_issue;
	issue_t          mul_issue;
	logic            alu_issue_valid;
	logic            mul_issue_valid;
	logic            alu_busy;
	logic            mul_busy;
	cdb_t            alu_request;
	cdb_t            mul_request;
	logic            alu_grant;
	logic            mul_grant;
	logic            retire_en;
	reg_idx_t        retire_reg;
	rob_tag_t        retire_tag;
	logic [XLEN-1:0] retire_value;

	////////////////////////////////////////////////////////////////////////////
	// Dispatch
	////////////////////////////////////////////////////////////////////////////

	assign dispatch_ready = !rob_full && !rs_full;
	assign dispatch_en    = in_valid && dispatch_ready;
	assign op_b           = in_instr.use_imm ? '{ready: 1'b1, tag: '0, value: in_instr.imm} : op2;

	rename_table rename_table_0 (
		.clock        (clock),
		.reset        (reset),
		.src1         (in_instr.rs1),
		.src2         (in_instr.rs2),
		.op1          (op1),
		.op2          (op2),
		.alloc_en     (dispatch_en),
		.alloc_reg    (in_instr.rd),
		.alloc_tag    (tail_tag),
		.retire_en    (retire_en),
		.retire_reg   (retire_reg),
		.retire_tag   (retire_tag),
		.retire_value (retire_value)
	);

	reservation_station #(.RS_DEPTH(RS_DEPTH)) reservation_station_0 (
		.clock           (clock),
		.reset           (reset),
		.disp_en         (dispatch_en),
		.disp_op         (in_instr.op),
		.disp_tag        (tail_tag),
		.disp_a          (op1),
		.disp_b          (op_b),
		.look_a          (look_a),
		.look_b          (look_b),
		.cdb             (cdb),
		.full            (rs_full),
		.alu_busy        (alu_busy),
		.mul_busy        (mul_busy),
		.alu_issue       (alu_issue),
		.mul_issue       (mul_issue),
		.alu_issue_valid (alu_issue_valid),
		.mul_issue_valid (mul_issue_valid)
	);

	////////////////////////////////////////////////////////////////////////////
	// Execute and broadcast
	////////////////////////////////////////////////////////////////////////////

	alu_unit alu_unit_0 (
		.clock       (clock),
		.reset       (reset),
		.issue       (alu_issue),
		.issue_valid (alu_issue_valid),
		.grant       (alu_grant),
		.busy        (alu_busy),
		.request     (alu_request)
	);

	multiplier_unit #(.MUL_STAGES(MUL_STAGES)) multiplier_unit_0 (
		.clock       (clock),
		.reset       (reset),
		.issue       (mul_issue),
		.issue_valid (mul_issue_valid),
		.grant       (mul_grant),
		.busy        (mul_busy),
		.request     (mul_request)
	);

	cdb_arbiter cdb_arbiter_0 (
		.clock       (clock),
		.reset       (reset),
		.alu_request (alu_request),
		.mul_request (mul_request),
		.alu_grant   (alu_grant),
		.mul_grant   (mul_grant),
		.cdb         (cdb)
	);

	// Queries use the rename tags even when the operand is already settled
	reorder_buffer reorder_buffer_0 (
		.clock        (clock),
		.reset        (reset),
		.alloc_en     (dispatch_en),
		.alloc_reg    (in_instr.rd),
		.tail_tag     (tail_tag),
		.full         (rob_full),
		.query_a      (op1.tag),
		.query_b      (op2.tag),
		.look_a       (look_a),
		.look_b       (look_b),
		.cdb          (cdb),
		.retire_en    (retire_en),
		.retire_reg   (retire_reg),
		.retire_tag   (retire_tag),
		.retire_value (retire_value),
		.commit_valid (commit_valid),
		.commit_reg   (commit_reg),
		.commit_value (commit_value)
	);

endmodule

`default_nettype wire

// File: source/rename_table.sv
`default_nettype none

module rename_table (
	input  wire                       clock,
	input  wire                       reset,
	input  wire isa_pkg::reg_idx_t    src1,
	input  wire isa_pkg::reg_idx_t    src2,
	output core_pkg::operand_t        op1,
	output core_pkg::operand_t        op2,
	input  wire                       alloc_en,
	input  wire isa_pkg::reg_idx_t    alloc_reg,
	input  wire core_pkg::rob_tag_t   alloc_tag,
	input  wire                       retire_en,
	input  wire isa_pkg::reg_idx_t    retire_reg,
	input  wire core_pkg::rob_tag_t   retire_tag,
	input  wire [isa_pkg::XLEN-1:0]   retire_value
);
	import isa_pkg::*;
	import core_pkg::*;

	logic [XLEN-1:0] regs [NUM_REGS];     // Architectural state
	logic            pending [NUM_REGS];  // Producer still in flight
	rob_tag_t        owner [NUM_REGS];    // Youngest producer tag

	// Value when settled, else the tag to wait on
	assign op1 = '{ready: !pending[src1], tag: owner[src1], value: regs[src1]};
	assign op2 = '{ready: !pending[src2], tag: owner[src2], value: regs[src2]};

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i]    <= '0;
				pending[i] <= 1'b0;
				owner[i]   <= '0;
			end
		end else begin
			if (retire_en) begin
				regs[retire_reg] <= retire_value;
				// Only drop the mapping if no younger writer took it over
				if (owner[retire_reg] == retire_tag)
					pending[retire_reg] <= 1'b0;
			end
			if (alloc_en) begin  // Comes last so it beats the clear
				pending[alloc_reg] <= 1'b1;
				owner[alloc_reg]   <= alloc_tag;
			end
		end
	end

endmodule

`default_nettype wire

// File: source/reorder_buffer.sv
`default_nettype none

module reorder_buffer (
	input  wire                       clock,
	input  wire                       reset,
	input  wire                       alloc_en,
	input  wire isa_pkg::reg_idx_t    alloc_reg,
	output core_pkg::rob_tag_t        tail_tag,
	output logic                      full,
	input  wire core_pkg::rob_tag_t   query_a,
	input  wire core_pkg::rob_tag_t   query_b,
	output core_pkg::rob_lookup_t     look_a,
	output core_pkg::rob_lookup_t     look_b,
	input  wire core_pkg::cdb_t       cdb,
	output logic                      retire_en,
	output isa_pkg::reg_idx_t         retire_reg,
	output core_pkg::rob_tag_t        retire_tag,
	output logic [isa_pkg::XLEN-1:0]  retire_value,
	output logic                      commit_valid,
	output isa_pkg::reg_idx_t         commit_reg,
	output logic [isa_pkg::XLEN-1:0]  commit_value
);
	import isa_pkg::*;
	import core_pkg::*;

	localparam int COUNT_W = $clog2(ROB_SIZE + 1);

	reg_idx_t            dest [ROB_SIZE];    // Destination register per entry
	logic [XLEN-1:0]     result [ROB_SIZE];  // Value from the bus
	logic [ROB_SIZE-1:0] done;
	rob_tag_t            head;               // Oldest entry
	rob_tag_t            tail;               // Next to allocate
	logic [COUNT_W-1:0]  count;

	assign tail_tag = tail;
	assign full     = count == COUNT_W'(ROB_SIZE);

	// Done implies live since the bit clears on retire and on allocation
	assign look_a = '{hit: done[query_a], value: result[query_a]};
	assign look_b = '{hit: done[query_b], value: result[query_b]};

	////////////////////////////////////////////////////////////////////////////
	// In-order retire
	////////////////////////////////////////////////////////////////////////////

	assign retire_en    = count != '0 && done[head];
	assign retire_reg   = dest[head];
	assign retire_tag   = head;
	assign retire_value = result[head];

	always_ff @(posedge clock) begin
		if (reset) begin
			head         <= '0;
			tail         <= '0;
			count        <= '0;
			done         <= '0;
			commit_valid <= 1'b0;
			commit_reg   <= '0;
			commit_value <= '0;
		end else begin
			if (retire_en) begin
				done[head] <= 1'b0;
				head       <= head + 1'b1;
			end
			if (alloc_en) begin
				done[tail] <= 1'b0;  // Fresh entry waits for its result
				tail       <= tail + 1'b1;
			end
			if (cdb.valid)
				done[cdb.tag] <= 1'b1;
			count        <= count + COUNT_W'(alloc_en) - COUNT_W'(retire_en);
			commit_valid <= retire_en;  // Reported one edge after retire
			commit_reg   <= retire_reg;
			commit_value <= retire_value;
		end
	end

	// Entry payload
	always_ff @(posedge clock) begin
		if (alloc_en)
			dest[tail] <= alloc_reg;
		if (cdb.valid)
			result[cdb.tag] <= cdb.value;
	end

endmodule

`default_nettype wire

// File: source/reservation_station.sv
`default_nettype none

module reservation_station #(
	parameter int RS_DEPTH = 4
) (
	input  wire                        clock,
	input  wire                        reset,
	input  wire                        disp_en,
	input  wire isa_pkg::opcode_t      disp_op,
	input  wire core_pkg::rob_tag_t    disp_tag,
	input  wire core_pkg::operand_t    disp_a,
	input  wire core_pkg::operand_t    disp_b,
	input  wire core_pkg::rob_lookup_t look_a,
	input  wire core_pkg::rob_lookup_t look_b,
	input  wire core_pkg::cdb_t        cdb,
	output logic                       full,
	input  wire                        alu_busy,
	input  wire                        mul_busy,
	output core_pkg::issue_t           alu_issue,
	output core_pkg::issue_t           mul_issue,
	output logic                       alu_issue_valid,
	output logic                       mul_issue_valid
);
	import isa_pkg::*;
	import core_pkg::*;

	localparam int IDX_W = (RS_DEPTH > 1) ? $clog2(RS_DEPTH) : 1;

	typedef struct packed {
		logic             valid;
		opcode_t          op;
		rob_tag_t         tag;   // Destination ROB entry
		operand_t         a;
		operand_t         b;
		logic [IDX_W-1:0] age;   // Number of younger live entries
	} rs_entry_t;

	rs_entry_t        entries [RS_DEPTH];
	logic [IDX_W-1:0] next_age [RS_DEPTH];
	logic [IDX_W-1:0] free_idx;
	logic [IDX_W-1:0] alu_idx;
	logic [IDX_W-1:0] mul_idx;
	logic             free_found;
	logic             alu_found;
	logic             mul_found;

	// Pick up a matching bus result
	function automatic operand_t wake(operand_t op, cdb_t bus);
		operand_t res;
		res = op;
		if (!op.ready && bus.valid && bus.tag == op.tag) begin
			res.ready = 1'b1;
			res.value = bus.value;
		end
		return res;
	endfunction

	// Dispatch path checks the ROB first and then the live bus
	function automatic operand_t resolve(operand_t op, rob_lookup_t look, cdb_t bus);
		operand_t res;
		res = op;
		if (!op.ready && look.hit) begin
			res.ready = 1'b1;
			res.value = look.value;
		end
		return wake(res, bus);
	endfunction

	function automatic issue_t to_issue(rs_entry_t e);
		return '{op: e.op, tag: e.tag, a: e.a.value, b: e.b.value};
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Free slot and oldest-ready select
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		free_found = 1'b0;
		free_idx   = '0;
		alu_found  = 1'b0;
		alu_idx    = '0;
		mul_found  = 1'b0;
		mul_idx    = '0;
		for (int i = RS_DEPTH - 1; i >= 0; i--) begin
			if (!entries[i].valid) begin  // Lowest index ends up chosen
				free_found = 1'b1;
				free_idx   = IDX_W'(i);
			end
		end
		for (int i = 0; i < RS_DEPTH; i++) begin
			if (entries[i].valid && entries[i].a.ready && entries[i].b.ready) begin
				if (entries[i].op == OP_MUL) begin
					if (!mul_found || entries[i].age > entries[mul_idx].age) begin
						mul_found = 1'b1;
						mul_idx   = IDX_W'(i);
					end
				end else if (!alu_found || entries[i].age > entries[alu_idx].age) begin
					alu_found = 1'b1;
					alu_idx   = IDX_W'(i);
				end
			end
		end
	end

	assign full            = !free_found;
	assign alu_issue_valid = alu_found && !alu_busy;  // One-cycle strobe
	assign mul_issue_valid = mul_found && !mul_busy;
	assign alu_issue       = to_issue(entries[alu_idx]);
	assign mul_issue       = to_issue(entries[mul_idx]);

	// Ages step up on dispatch and close the gap left by an issued younger entry
	always_comb begin
		for (int i = 0; i < RS_DEPTH; i++) begin
			next_age[i] = entries[i].age + IDX_W'(disp_en);
			if (alu_issue_valid && entries[i].age > entries[alu_idx].age)
				next_age[i] = next_age[i] - 1'b1;
			if (mul_issue_valid && entries[i].age > entries[mul_idx].age)
				next_age[i] = next_age[i] - 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Entry update
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < RS_DEPTH; i++)
				entries[i] <= '0;
		end else begin
			for (int i = 0; i < RS_DEPTH; i++) begin
				entries[i].a   <= wake(entries[i].a, cdb);  // Snoop the bus
				entries[i].b   <= wake(entries[i].b, cdb);
				entries[i].age <= next_age[i];
			end
			if (alu_issue_valid)
				entries[alu_idx].valid <= 1'b0;
			if (mul_issue_valid)
				entries[mul_idx].valid <= 1'b0;
			if (disp_en) begin  // Newest entry starts at age zero
				entries[free_idx] <= '{
					valid: 1'b1,
					op:    disp_op,
					tag:   disp_tag,
					a:     resolve(disp_a, look_a, cdb),
					b:     resolve(disp_b, look_b, cdb),
					age:   '0
				};
			end
		end
	end

endmodule

`default_nettype wire

// File: tb.f
source/isa_pkg.sv
source/core_pkg.sv
source/rename_table.sv
source/reservation_station.sv
source/alu_unit.sv
source/multiplier_unit.sv
source/cdb_arbiter.sv
source/reorder_buffer.sv
source/ooo_core.sv
verification/ooo_core_tb.sv

// File: verification/ooo_core_tb.sv
`default_nettype none

module ooo_core_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import isa_pkg::*;

	localparam int          CLOCK_PERIOD = 10;
	localparam logic [31:0] SEED         = 32'hf476_a0d6;
	localparam int          RANDOM_COUNT = 300;
	localparam int          TOTAL_INSTRS = 14 + 12 + 10 + 30 + 16 + RANDOM_COUNT;
	// 40 cycles per dispatched instruction, plus reset and the final drain
	localparam longint      TIMEOUT_NS   = longint'(40) * TOTAL_INSTRS * CLOCK_PERIOD + 500;

	// Expected retirement, one per dispatched instruction
	typedef struct packed {
		reg_idx_t        rd;
		logic [XLEN-1:0] value;
	} commit_t;

	logic            clock;
	logic            reset;
	logic            in_valid;
	instr_t          in_instr;
	logic            dispatch_ready;
	logic            commit_valid;
	reg_idx_t        commit_reg;
	logic [XLEN-1:0] commit_value;

	logic [XLEN-1:0] model_regs [NUM_REGS];  // Reference register file
	commit_t         expected [$];           // Program order
	int              checks;
	int              errors;
	int              commits;
	int              errors_at_start;
	int              commits_at_start;
	int              sent_in_test;

	ooo_core #(.RS_DEPTH(4), .MUL_STAGES(3)) uut (
		.clock          (clock),
		.reset          (reset),
		.in_valid       (in_valid),
		.in_instr       (in_instr),
		.dispatch_ready (dispatch_ready),
		.commit_valid   (commit_valid),
		.commit_reg     (commit_reg),
		.commit_value   (commit_value)
	);

	always #(CLOCK_PERIOD / 2) clock = !clock;

	////////////////////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [XLEN-1:0] expected_value(opcode_t op, logic [XLEN-1:0] a,
		logic [XLEN-1:0] b);
		case (op)
			OP_ADD:  return a + b;
			OP_SUB:  return a - b;
			OP_AND:  return a & b;
			OP_OR:   return a | b;
			OP_XOR:  return a ^ b;
			OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			OP_MUL:  return a * b;  // Low word of the product
			default: return '0;
		endcase
	endfunction

	function automatic void apply_to_model(instr_t ins);
		logic [XLEN-1:0] b;
		b = ins.use_imm ? ins.imm : model_regs[ins.rs2];
		model_regs[ins.rd] = expected_value(ins.op, model_regs[ins.rs1], b);
		expected.push_back('{rd: ins.rd, value: model_regs[ins.rd]});
	endfunction

	function automatic instr_t make_instr(opcode_t op, int rd, int rs1, int rs2, bit use_imm,
		logic [XLEN-1:0] imm);
		instr_t ins;
		ins.op      = op;
		ins.rd      = reg_idx_t'(rd);
		ins.rs1     = reg_idx_t'(rs1);
		ins.rs2     = reg_idx_t'(rs2);
		ins.use_imm = use_imm;
		ins.imm     = imm;
		return ins;
	endfunction

	// Commit outputs are registered and settled by the falling edge
	always @(negedge clock) begin : commit_monitor
		commit_t got;
		commit_t want;
		if (!reset && commit_valid) begin
			got = '{rd: commit_reg, value: commit_value};
			commits++;
			if (expected.size() == 0) begin
				$display("Unexpected commit of r%0d at %0t with no instruction left to retire",
					commit_reg, $time);
				errors++;
			end else begin
				want = expected.pop_front();
				checks++;
				if (got != want) begin
					$display("Fail %0t: commit r%0d = %h, expected r%0d = %h", $time,
						got.rd, got.value, want.rd, want.value);
					errors++;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Driver helpers enter and leave on a falling edge
	////////////////////////////////////////////////////////////////////////////

	task automatic send_instr(input instr_t ins);
		logic taken;
		taken    = 1'b0;
		in_valid = 1'b1;
		in_instr = ins;
		while (!taken) begin
			taken = dispatch_ready;  // Depends on state only, steady until the edge
			@(negedge clock);
		end
		in_valid = 1'b0;
		apply_to_model(ins);
		sent_in_test++;
	endtask

	task automatic wait_cycles(input int cycles);
		repeat (cycles) @(negedge clock);
	endtask

	task automatic open_test();
		errors_at_start  = errors;
		commits_at_start = commits;
		sent_in_test     = 0;
	endtask

	// Drain, then one line per test
	task automatic close_test(input string name);
		while (expected.size() != 0)
			@(negedge clock);
		checks++;
		if (commits - commits_at_start != sent_in_test) begin
			$display("Test %s retired %0d instructions but %0d were sent", name,
				commits - commits_at_start, sent_in_test);
			errors++;
		end
		if (errors == errors_at_start)
			$display("test %s: pass", name);
		else
			$display("test %s: fail, %0d errors", name, errors - errors_at_start);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////////////////////

	task automatic reset_and_basic_ops();
		logic [XLEN-1:0] imm;
		open_test();
		checks += 2;
		if (dispatch_ready !== 1'b1) begin
			$display("Fail %0t: dispatch_ready not high after reset", $time);
			errors++;
		end
		if (commit_valid !== 1'b0) begin
			$display("Fail %0t: commit_valid not low after reset", $time);
			errors++;
		end
		// Sources stay in r0..r3, never written here
		for (int i = 0; i < 7; i++) begin
			imm = (i % 2 == 1) ? 32'hffff_fff0 + i : 32'h0000_0123 * (i + 1);
			send_instr(make_instr(opcode_t'(i), 8 + i, i % 4, (i + 1) % 4, 1'b0, '0));
			send_instr(make_instr(opcode_t'(i), 4 + i % 4, (i + 2) % 4, 0, 1'b1, imm));
		end
		close_test("reset_and_basic_ops");
	endtask

	task automatic dependence_chain();
		int prev;
		int rd;
		open_test();
		send_instr(make_instr(OP_ADD, 4, 0, 0, 1'b1, $urandom));  // Chain seed
		prev = 4;
		for (int i = 1; i < 12; i++) begin
			rd = 4 + i % 3;
			send_instr(make_instr(opcode_t'(i % 7), rd, prev, 4 + (i + 1) % 3, i % 2 == 1,
				$urandom));
			prev = rd;
		end
		close_test("dependence_chain");
	endtask

	task automatic out_of_order_completion();
		open_test();
		send_instr(make_instr(OP_MUL, 8, 4, 5, 1'b0, '0));
		send_instr(make_instr(OP_MUL, 9, 8, 0, 1'b1, 32'h0000_7f31));  // Waits on a MUL
		send_instr(make_instr(OP_MUL, 10, 5, 6, 1'b0, '0));
		// Sources r4..r7 carry nonzero values from earlier tests
		for (int i = 0; i < 7; i++)  // Independent, finish first
			send_instr(make_instr(opcode_t'(i % 6), 11 + i % 5, 4 + i % 3, 4 + (i + 1) % 4,
				i == 3, 32'h8000_0011));
		close_test("out_of_order_completion");
	endtask

	task automatic back_pressure_burst();
		opcode_t op;
		open_test();
		for (int i = 0; i < 30; i++) begin
			op = (i % 4 == 3) ? OP_ADD : OP_MUL;
			send_instr(make_instr(op, $urandom_range(15, 0), $urandom_range(15, 0),
				$urandom_range(15, 0), i % 5 == 0, $urandom));
		end
		close_test("back_pressure_burst");
	endtask

	task automatic bus_contention();
		opcode_t op;
		open_test();
		// Sources r0..r3, destinations r4 and up
		// Each pair puts a product and an ALU result on the bus in the same cycle
		for (int i = 0; i < 16; i += 2) begin
			op = opcode_t'((i / 2) % 6);
			send_instr(make_instr(OP_MUL, 5 + i % 12, (i + 1) % 4, i % 4, 1'b0, '0));
			wait_cycles(1);  // ALU catches up with the multiplier pipe
			send_instr(make_instr(op, 4 + i % 12, i % 4, (i + 3) % 4, 1'b0, '0));
			wait_cycles(3);  // Both units idle again
		end
		close_test("bus_contention");
	endtask

	task automatic random_mix();
		open_test();
		for (int i = 0; i < RANDOM_COUNT; i++) begin
			send_instr(make_instr(opcode_t'($urandom_range(6, 0)), $urandom_range(15, 0),
				$urandom_range(15, 0), $urandom_range(15, 0), $urandom_range(1, 0) == 1,
				$urandom));
			wait_cycles($urandom_range(3, 0));  // Idle gap
		end
		close_test("random_mix");
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence and watchdog
	////////////////////////////////////////////////////////////////////////////

	initial begin
		void'($urandom(SEED));
		clock            = 1'b0;
		reset            = 1'b1;
		in_valid         = 1'b0;
		in_instr         = '0;
		checks           = 0;
		errors           = 0;
		commits          = 0;
		errors_at_start  = 0;
		commits_at_start = 0;
		sent_in_test     = 0;
		for (int i = 0; i < NUM_REGS; i++)
			model_regs[i] = '0;
		repeat (3) @(negedge clock);  // Three rising edges in reset
		reset = 1'b0;
		reset_and_basic_ops();
		dependence_chain();
		out_of_order_completion();
		back_pressure_burst();
		bus_contention();
		random_mix();
		wait_cycles(20);  // Any stray commit shows up here
		$display("checks %0d, errors %0d, commits %0d", checks, errors, commits);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("Timeout: run did not finish within %0d ns", TIMEOUT_NS);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire
